// ==== verilog/uart_pkg.sv ====
package uart_pkg;

    // --------------------
    // Bus address map
    // --------------------

    // Status word, read only
    localparam logic [31:0] ADDR_STATUS  = 32'h8000_0000;

    // Receive data word, read only
    localparam logic [31:0] ADDR_RX_DATA = 32'h8000_0004;

    // Transmit data word, write only
    localparam logic [31:0] ADDR_TX_DATA = 32'h8000_0008;

    // --------------------
    // Status word bits
    // --------------------

    // Transmitter can take a byte
    localparam int STATUS_TX_READY = 0;

    // Received byte waiting to be read
    localparam int STATUS_RX_VALID = 1;

    // --------------------
    // 8N1 frame
    // --------------------

    localparam int DATA_BITS = 8;

    // Start bit, data bits and stop bit
    localparam int FRAME_BITS = DATA_BITS + 2;

endpackage

// ==== verilog/uart_tx.sv ====
`timescale 1ns/1ns

module uart_tx
    import uart_pkg::*;
#(
    parameter int CLOCKS_PER_BIT = 16
)
(
    input  logic                 Clock,
    input  logic                 arst_n,
    input  logic [DATA_BITS-1:0] tx_data,
    input  logic                 tx_valid,
    output logic                 tx_ready,
    output logic                 serial_out
);

    localparam int TIMER_W = $clog2(CLOCKS_PER_BIT);
    localparam int COUNT_W = $clog2(FRAME_BITS);

    // Bits still to go after the start bit: data then stop
    logic [FRAME_BITS-2:0] shift_reg;
    logic [TIMER_W-1:0]    bit_timer;
    logic [COUNT_W-1:0]    bit_count;
    logic                  busy;
    logic                  accept;
    logic                  bit_done;

    assign tx_ready = ~busy;
    assign accept   = tx_valid & ~busy;
    assign bit_done = (bit_timer == TIMER_W'(CLOCKS_PER_BIT - 1));

    // --------------------
    // Control state
    // --------------------

    always_ff @(posedge Clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            busy       <= 1'b0;
            bit_timer  <= '0;
            bit_count  <= '0;
            serial_out <= 1'b1;
        end
        else if (accept)
        begin
            // Start bit goes out on the next cycle
            busy       <= 1'b1;
            bit_timer  <= '0;
            bit_count  <= '0;
            serial_out <= 1'b0;
        end
        else if (busy)
        begin
            if (bit_done)
            begin
                bit_timer <= '0;
                if (bit_count == COUNT_W'(FRAME_BITS - 1))
                begin
                    // End of stop bit, line already high
                    busy <= 1'b0;
                end
                else
                begin
                    serial_out <= shift_reg[0];
                    bit_count  <= bit_count + 1'b1;
                end
            end
            else
            begin
                bit_timer <= bit_timer + 1'b1;
            end
        end
    end

    // --------------------
    // Payload shifter
    // --------------------

    always_ff @(posedge Clock)
    begin
        if (accept)
        begin
            // Stop bit on top, data LSB first
            shift_reg <= {1'b1, tx_data};
        end
        else if (busy && bit_done)
        begin
            shift_reg <= {1'b1, shift_reg[FRAME_BITS-2:1]};
        end
    end

endmodule

// ==== verilog/uart_rx.sv ====
`timescale 1ns/1ns

module uart_rx
    import uart_pkg::*;
#(
    parameter int CLOCKS_PER_BIT = 16
)
(
    input  logic                 Clock,
    input  logic                 arst_n,
    input  logic                 serial_in_sync,
    input  logic                 rx_ready,
    output logic [DATA_BITS-1:0] rx_data,
    output logic                 rx_valid
);

    localparam int TIMER_W  = $clog2(CLOCKS_PER_BIT);
    localparam int INDEX_W  = $clog2(DATA_BITS);
    localparam int HALF_BIT = CLOCKS_PER_BIT / 2;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t            state;
    logic                 prev_in;
    logic [TIMER_W-1:0]   bit_timer;
    logic [INDEX_W-1:0]   bit_index;
    logic [DATA_BITS-1:0] data_shift;
    logic                 half_done;
    logic                 bit_done;
    logic                 frame_good;

    assign half_done  = (bit_timer == TIMER_W'(HALF_BIT - 1));
    assign bit_done   = (bit_timer == TIMER_W'(CLOCKS_PER_BIT - 1));
    assign frame_good = (state == RX_STOP) && bit_done && serial_in_sync;

    // --------------------
    // Frame FSM
    // --------------------

    always_ff @(posedge Clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state     <= RX_IDLE;
            prev_in   <= 1'b1;
            bit_timer <= '0;
            bit_index <= '0;
        end
        else
        begin
            prev_in <= serial_in_sync;
            case (state)
                RX_IDLE:
                begin
                    bit_timer <= '0;
                    // Falling edge marks a possible start bit
                    if (prev_in && !serial_in_sync)
                    begin
                        state <= RX_START;
                    end
                end
                RX_START:
                begin
                    if (half_done)
                    begin
                        bit_timer <= '0;
                        bit_index <= '0;
                        // Glitch if the line is high again at mid start bit
                        state     <= serial_in_sync ? RX_IDLE : RX_DATA;
                    end
                    else
                    begin
                        bit_timer <= bit_timer + 1'b1;
                    end
                end
                RX_DATA:
                begin
                    if (bit_done)
                    begin
                        bit_timer <= '0;
                        bit_index <= bit_index + 1'b1;
                        if (bit_index == INDEX_W'(DATA_BITS - 1))
                        begin
                            state <= RX_STOP;
                        end
                    end
                    else
                    begin
                        bit_timer <= bit_timer + 1'b1;
                    end
                end
                RX_STOP:
                begin
                    if (bit_done)
                    begin
                        // Bad stop bit drops the frame
                        bit_timer <= '0;
                        state     <= RX_IDLE;
                    end
                    else
                    begin
                        bit_timer <= bit_timer + 1'b1;
                    end
                end
                default:
                begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // Data sampled at bit centers, LSB first
    always_ff @(posedge Clock)
    begin
        if (state == RX_DATA && bit_done)
        begin
            data_shift <= {serial_in_sync, data_shift[DATA_BITS-1:1]};
        end
        if (frame_good)
        begin
            rx_data <= data_shift;
        end
    end

    // --------------------
    // Holding flag
    // --------------------

    // A new frame wins over a read in the same cycle
    always_ff @(posedge Clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rx_valid <= 1'b0;
        end
        else if (frame_good)
        begin
            rx_valid <= 1'b1;
        end
        else if (rx_ready)
        begin
            rx_valid <= 1'b0;
        end
    end

endmodule

// ==== verilog/uart.sv ====
`timescale 1ns/1ns

module uart
    import uart_pkg::*;
#(
    parameter int CLOCKS_PER_BIT = 16
)
(
    input  logic                 Clock,
    input  logic                 arst_n,
    input  logic [DATA_BITS-1:0] tx_data,
    input  logic                 tx_valid,
    output logic                 tx_ready,
    output logic [DATA_BITS-1:0] rx_data,
    output logic                 rx_valid,
    input  logic                 rx_ready,
    input  logic                 serial_in,
    output logic                 serial_out
);

    logic sync_meta;
    logic sync_out;

    // Two flops on the asynchronous line, idle high out of reset
    always_ff @(posedge Clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sync_meta <= 1'b1;
            sync_out  <= 1'b1;
        end
        else
        begin
            sync_meta <= serial_in;
            sync_out  <= sync_meta;
        end
    end

    uart_tx #(
        .CLOCKS_PER_BIT (CLOCKS_PER_BIT)
    ) uart_tx_inst (
        .Clock      (Clock),
        .arst_n     (arst_n),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .serial_out (serial_out)
    );

    uart_rx #(
        .CLOCKS_PER_BIT (CLOCKS_PER_BIT)
    ) uart_rx_inst (
        .Clock          (Clock),
        .arst_n         (arst_n),
        .serial_in_sync (sync_out),
        .rx_ready       (rx_ready),
        .rx_data        (rx_data),
        .rx_valid       (rx_valid)
    );

endmodule

// ==== verilog/io_interface.sv ====
`timescale 1ns/1ns

module io_interface
    import uart_pkg::*;
#(
    parameter int CLOCKS_PER_BIT = 16
)
(
    input  logic        Clock,
    input  logic        arst_n,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic [3:0]  be,
    input  logic        wr,
    input  logic        rd,
    input  logic        serial_in,
    output logic        serial_out,
    output logic [31:0] rdata
);

    logic [DATA_BITS-1:0] tx_data;
    logic                 tx_valid;
    logic                 tx_ready;
    logic [DATA_BITS-1:0] rx_data;
    logic                 rx_valid;
    logic                 rx_ready;
    logic [31:0]          read_word;

    // --------------------
    // Write side
    // --------------------

    // Lost if the transmitter is busy
    assign tx_valid = wr && (addr == ADDR_TX_DATA) && (be != 4'b0000);

    // Lowest enabled byte lane
    always_comb
    begin
        if (be[0])
        begin
            tx_data = wdata[7:0];
        end
        else if (be[1])
        begin
            tx_data = wdata[15:8];
        end
        else if (be[2])
        begin
            tx_data = wdata[23:16];
        end
        else
        begin
            tx_data = wdata[31:24];
        end
    end

    // --------------------
    // Read side
    // --------------------

    assign rx_ready = rd && (addr == ADDR_RX_DATA) && rx_valid;

    always_comb
    begin
        read_word = '0;
        if (rd)
        begin
            case (addr)
                ADDR_STATUS:
                begin
                    read_word[STATUS_TX_READY] = tx_ready;
                    read_word[STATUS_RX_VALID] = rx_valid;
                end
                ADDR_RX_DATA:
                begin
                    // Nothing held reads as zero
                    if (rx_valid)
                    begin
                        read_word = {{(32 - DATA_BITS){1'b0}}, rx_data};
                    end
                end
                default:
                begin
                    read_word = '0;
                end
            endcase
        end
    end

    // Zero whenever the previous cycle had no read
    always_ff @(posedge Clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rdata <= '0;
        end
        else
        begin
            rdata <= read_word;
        end
    end

    uart #(
        .CLOCKS_PER_BIT (CLOCKS_PER_BIT)
    ) uart_inst (
        .Clock      (Clock),
        .arst_n     (arst_n),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready),
        .serial_in  (serial_in),
        .serial_out (serial_out)
    );

endmodule

// ==== bench/io_interface_chk.sv ====
`timescale 1ns/1ns

module io_interface_chk
(
    input logic        Clock,
    input logic        arst_n,
    input logic        rd,
    input logic        wr,
    input logic [31:0] rdata,
    input logic        serial_out,
    input logic        tx_ready
);

    // --------------------
    // Reset and bus rules
    // --------------------

    // Line idles high in reset
    assert property (@(posedge Clock) !arst_n |=> serial_out)
    else $error("serial_out low while in reset");

    assert property (@(posedge Clock) disable iff (!arst_n) !(rd && wr))
    else $error("rd and wr asserted together");

    assert property (@(posedge Clock) disable iff (!arst_n) !rd |=> (rdata == 32'h0))
    else $error("rdata nonzero after a cycle with no read");

    // --------------------
    // Frame rules
    // --------------------

    assert property (@(posedge Clock) disable iff (!arst_n) !serial_out |-> !tx_ready)
    else $error("tx_ready high during a frame");

    // Transmitter frees up only after the stop bit
    assert property (@(posedge Clock) disable iff (!arst_n) $rose(tx_ready) |-> serial_out)
    else $error("tx_ready rose while serial_out low");

endmodule

bind io_interface io_interface_chk io_interface_chk_inst (
    .Clock      (Clock),
    .arst_n     (arst_n),
    .rd         (rd),
    .wr         (wr),
    .rdata      (rdata),
    .serial_out (serial_out),
    .tx_ready   (tx_ready)
);

// ==== bench/io_interface_tb.sv ====
`timescale 1ns/1ns

module io_interface_tb
    import uart_pkg::*;
();

    localparam int CLOCKS_PER_BIT  = 16;
    localparam int FRAME_CYCLES    = FRAME_BITS * CLOCKS_PER_BIT;
    localparam int POLL_LIMIT      = FRAME_CYCLES;
    // Frame 1, lanes 3, busy drop 2, random 20
    localparam int FRAME_TIMES     = 26;
    localparam int WATCHDOG_CYCLES = FRAME_TIMES * FRAME_CYCLES * 2 + 2000;

    logic        Clock;
    logic        arst_n;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  be;
    logic        wr;
    logic        rd;
    wire         serial_in;
    wire         serial_out;
    wire  [31:0] rdata;

    logic [7:0]  decoded_q[$];
    logic [7:0]  expect_q[$];
    logic [7:0]  got_byte;
    logic [7:0]  exp_byte;
    logic [31:0] rng_state;
    int          value_errors;
    int          other_errors;
    int          frames_seen;

    io_interface #(
        .CLOCKS_PER_BIT (CLOCKS_PER_BIT)
    ) io_interface_inst (
        .Clock      (Clock),
        .arst_n     (arst_n),
        .addr       (addr),
        .wdata      (wdata),
        .be         (be),
        .wr         (wr),
        .rd         (rd),
        .serial_in  (serial_in),
        .serial_out (serial_out),
        .rdata      (rdata)
    );

    // Serial loopback
    assign serial_in = serial_out;

    always #50 Clock = ~Clock;

    // --------------------
    // Reference model
    // --------------------

    // Bit 8 set when a frame goes out, low byte is the lowest enabled lane
    function automatic logic [8:0] expected_frame(input logic [31:0] data, input logic [3:0] en);
        for (int lane = 0; lane < 4; lane++)
        begin
            if (en[lane])
            begin
                return {1'b1, data[8*lane +: 8]};
            end
        end
        return 9'h000;
    endfunction

    function automatic logic [31:0] expected_status(input logic tx_rdy, input logic rx_vld);
        logic [31:0] word;
        word = 32'h0;
        word[STATUS_TX_READY] = tx_rdy;
        word[STATUS_RX_VALID] = rx_vld;
        return word;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // --------------------
    // Bus tasks
    // --------------------

    task automatic write_bus(input logic [31:0] a, input logic [31:0] d, input logic [3:0] en);
        @(posedge Clock);
        #5;
        addr  = a;
        wdata = d;
        be    = en;
        wr    = 1'b1;
        @(posedge Clock);
        #5;
        wr = 1'b0;
        be = 4'b0000;
    endtask

    // Result is registered, so sample one cycle after the strobe
    task automatic read_bus(input logic [31:0] a, output logic [31:0] d);
        @(posedge Clock);
        #5;
        addr = a;
        rd   = 1'b1;
        @(posedge Clock);
        #5;
        rd = 1'b0;
        d  = rdata;
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else
        begin
            $display("[ERROR] %s expected 0x%08h actual 0x%08h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic poll_status(input int bit_pos, input logic level, input string what);
        logic [31:0] word;
        int          polls;
        polls = 0;
        read_bus(ADDR_STATUS, word);
        while (word[bit_pos] !== level && polls < POLL_LIMIT)
        begin
            polls++;
            read_bus(ADDR_STATUS, word);
        end
        assert (word[bit_pos] === level)
        else
        begin
            $display("Gave up polling status for %s after %0d reads", what, polls);
            other_errors++;
        end
    endtask

    // One transmit write, then loopback receive and status checks
    task automatic send_and_check(input logic [31:0] data, input logic [3:0] en);
        logic [8:0]  exp;
        logic [31:0] word;
        exp = expected_frame(data, en);
        write_bus(ADDR_TX_DATA, data, en);
        if (exp[8])
        begin
            expect_q.push_back(exp[7:0]);
            poll_status(STATUS_RX_VALID, 1'b1, "rx valid");
            read_bus(ADDR_RX_DATA, word);
            check_word("rdata", {24'h0, exp[7:0]}, word);
            poll_status(STATUS_TX_READY, 1'b1, "tx ready");
        end
        else
        begin
            repeat (FRAME_CYCLES + 20) @(posedge Clock);
        end
        read_bus(ADDR_STATUS, word);
        check_word("rdata", expected_status(1'b1, 1'b0), word);
    endtask

    // --------------------
    // Frame monitor
    // --------------------

    initial
    begin : frame_monitor
        logic [7:0] bits;
        wait (arst_n === 1'b1);
        forever
        begin
            @(negedge serial_out);
            // Middle of the start bit
            repeat (CLOCKS_PER_BIT / 2) @(posedge Clock);
            #1;
            assert (serial_out === 1'b0)
            else
            begin
                $display("Start bit on serial_out was high again at its middle");
                other_errors++;
            end
            if (serial_out === 1'b0)
            begin
                for (int i = 0; i < DATA_BITS; i++)
                begin
                    repeat (CLOCKS_PER_BIT) @(posedge Clock);
                    #1;
                    bits[i] = serial_out;
                end
                repeat (CLOCKS_PER_BIT) @(posedge Clock);
                #1;
                assert (serial_out === 1'b1)
                else
                begin
                    $display("Stop bit on serial_out was low");
                    other_errors++;
                end
                decoded_q.push_back(bits);
            end
        end
    end

    // Decoded bytes against the expected queue
    always @(posedge Clock)
    begin
        if (decoded_q.size() > 0)
        begin
            got_byte = decoded_q.pop_front();
            frames_seen++;
            assert (expect_q.size() > 0)
            else
            begin
                $display("Frame 0x%02h appeared with no write expecting it", got_byte);
                other_errors++;
            end
            if (expect_q.size() > 0)
            begin
                exp_byte = expect_q.pop_front();
                assert (got_byte === exp_byte)
                else
                begin
                    $display("[ERROR] serial_out expected 0x%02h actual 0x%02h",
                             exp_byte, got_byte);
                    value_errors++;
                end
            end
        end
    end

    initial
    begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge Clock);
        $display("Run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors: %0d value, %0d other", value_errors, other_errors + 1);
        $display("Regression failed");
        $finish;
    end

    // --------------------
    // Test sequence
    // --------------------

    initial
    begin : stimulus
        logic [31:0] word;
        logic [31:0] data;
        logic [3:0]  en;
        Clock        = 1'b0;
        arst_n       = 1'b0;
        addr         = 32'h0;
        wdata        = 32'h0;
        be           = 4'b0000;
        wr           = 1'b0;
        rd           = 1'b0;
        rng_state    = 32'h229;
        value_errors = 0;
        other_errors = 0;
        frames_seen  = 0;
        repeat (4) @(posedge Clock);
        #5;
        arst_n = 1'b1;

        // Reset state
        check_word("serial_out", 32'h1, {31'h0, serial_out});
        read_bus(ADDR_STATUS, word);
        check_word("rdata", expected_status(1'b1, 1'b0), word);

        // Frame format and loopback
        send_and_check(32'h1234_56A5, 4'b0001);

        // Byte lanes, be zero sends nothing
        send_and_check(32'hDEAD_BEEF, 4'b0100);
        send_and_check(32'h5A3C_9612, 4'b1100);
        send_and_check(32'h7777_7777, 4'b0000);

        // Second write while busy is dropped
        write_bus(ADDR_TX_DATA, 32'h0000_003C, 4'b0001);
        expect_q.push_back(8'h3C);
        read_bus(ADDR_STATUS, word);
        check_word("rdata", expected_status(1'b0, 1'b0), word);
        write_bus(ADDR_TX_DATA, 32'h0000_00C3, 4'b0001);
        poll_status(STATUS_RX_VALID, 1'b1, "rx valid");
        read_bus(ADDR_RX_DATA, word);
        check_word("rdata", 32'h0000_003C, word);
        poll_status(STATUS_TX_READY, 1'b1, "tx ready");
        repeat (FRAME_CYCLES + 20) @(posedge Clock);
        read_bus(ADDR_STATUS, word);
        check_word("rdata", expected_status(1'b1, 1'b0), word);

        // Random traffic
        for (int n = 0; n < 20; n++)
        begin
            rng_state = xorshift32(rng_state);
            data      = rng_state;
            rng_state = xorshift32(rng_state);
            en        = (rng_state[3:0] == 4'b0000) ? 4'b1000 : rng_state[3:0];
            poll_status(STATUS_TX_READY, 1'b1, "tx ready");
            send_and_check(data, en);
        end

        repeat (10) @(posedge Clock);
        assert (expect_q.size() == 0)
        else
        begin
            $display("%0d written bytes never appeared on serial_out", expect_q.size());
            other_errors++;
        end
        $display("Errors: %0d value, %0d other, frames decoded %0d",
                 value_errors, other_errors, frames_seen);
        if (value_errors == 0 && other_errors == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
verilog/uart_pkg.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart.sv
verilog/io_interface.sv
bench/io_interface_chk.sv
bench/io_interface_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the io_interface regression with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module io_interface_tb -f sources.f &&
./obj_dir/Vio_interface_tb | tee /dev/stderr | grep -q "Regression passed" &&
echo "run.sh: PASS" ||
{ echo "run.sh: FAIL"; exit 1; }
